// File: Makefile
# Verilator build and run of the dispatch stage testbench

TOP := tb_dispatch_stage

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module dispatch_stage

clean:
	rm -rf obj_dir

// File: rtl/busy_table.sv
// Busy table
// One pending bit per physical register, set on allocation, cleared on
// writeback, looked up for the source operands of incoming instructions

`default_nettype none

`include "dispatch_cfg.svh"

module busy_table (
	input  logic                                    clk,
	input  logic                                    rst_n,
	// Destination allocation from the decode lanes
	input  logic [`DECODE_WIDTH-1:0]                alloc_valid_i,
	input  preg_pkg::preg_t [`DECODE_WIDTH-1:0]     alloc_pdest_i,
	// Writeback broadcast
	input  preg_pkg::wb_mask_t                      wb_valid_i,
	input  preg_pkg::wb_preg_t                      wb_pdest_i,
	// Source lookup per decode lane
	input  preg_pkg::preg_t [`DECODE_WIDTH-1:0]     look_src0_i,
	input  preg_pkg::preg_t [`DECODE_WIDTH-1:0]     look_src1_i,
	input  logic [`DECODE_WIDTH-1:0]                look_en0_i,
	input  logic [`DECODE_WIDTH-1:0]                look_en1_i,
	output logic [`DECODE_WIDTH-1:0]                src0_ready_o,
	output logic [`DECODE_WIDTH-1:0]                src1_ready_o
);

	logic [`PHY_REG_NUM-1:0] busy_q, busy_n;
	// Decoded one-hot views of this cycle's events
	logic [`PHY_REG_NUM-1:0] wb_hit;
	logic [`PHY_REG_NUM-1:0] alloc_hit;

	// ====================
	// Event decode
	// ====================

	always_comb begin
		wb_hit    = '0;
		alloc_hit = '0;
		for (int w = 0; w < `WB_WIDTH; w++) begin
			if (wb_valid_i[w]) begin
				wb_hit[wb_pdest_i[w]] = 1'b1;
			end
		end
		for (int i = 0; i < `DECODE_WIDTH; i++) begin
			if (alloc_valid_i[i]) begin
				alloc_hit[alloc_pdest_i[i]] = 1'b1;
			end
		end
		// Allocation wins over a same-cycle writeback
		busy_n = (busy_q & ~wb_hit) | alloc_hit;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q <= '0;
		end else begin
			busy_q <= busy_n;
		end
	end

	// ====================
	// Source lookup
	// ====================

	// Ready when unused, not pending, or written back right now
	always_comb begin
		for (int i = 0; i < `DECODE_WIDTH; i++) begin
			src0_ready_o[i] = !look_en0_i[i] || !busy_q[look_src0_i[i]] ||
				wb_hit[look_src0_i[i]];
			src1_ready_o[i] = !look_en1_i[i] || !busy_q[look_src1_i[i]] ||
				wb_hit[look_src1_i[i]];
		end
	end

	// Rename must hand out distinct destinations within a group
	for (genvar i = 0; i < `DECODE_WIDTH; i++) begin : g_alloc_a
		for (genvar j = i + 1; j < `DECODE_WIDTH; j++) begin : g_alloc_b
			a_alloc_unique: assert property (@(posedge clk) disable iff (!rst_n)
				!(alloc_valid_i[i] && alloc_valid_i[j] &&
				alloc_pdest_i[i] == alloc_pdest_i[j]))
				else $error("busy_table: lanes %0d and %0d allocate one register", i, j);
		end
	end

endmodule

`default_nettype wire

// File: rtl/dispatch_cfg.svh
// Dispatch stage configuration
// Lane counts, register file size and queue depth shared by all blocks

`ifndef DISPATCH_CFG_SVH
`define DISPATCH_CFG_SVH

// ====================
// Lane widths
// ====================

// Renamed instructions accepted per cycle
`define DECODE_WIDTH 2

// Instructions sent to the issue ports per cycle
`define DISPATCH_WIDTH 2

// Writeback broadcast ports
`define WB_WIDTH 2

// ====================
// Storage sizes
// ====================

// Physical register file entries
`define PHY_REG_NUM 32

// Dispatch queue entries, keep a power of two
`define DQ_DEPTH 8

`endif

// File: rtl/dispatch_queue.sv
// Dispatch queue
// In-order circular buffer, several writes at the tail and several reads
// at the head per cycle, with writeback wakeup of the source ready bits

`default_nettype none

`include "dispatch_cfg.svh"

module dispatch_queue #(
	parameter int unsigned DEPTH = `DQ_DEPTH
) (
	input  logic                                     clk,
	input  logic                                     rst_n,
	input  logic                                     flush_i,
	// Tail side
	input  logic [`DECODE_WIDTH-1:0]                 write_valid_i,
	input  dq_pkg::dq_entry_t [`DECODE_WIDTH-1:0]    write_data_i,
	output logic                                     write_ready_o,
	// Head side
	output logic [`DISPATCH_WIDTH-1:0]               read_valid_o,
	output dq_pkg::dq_entry_t [`DISPATCH_WIDTH-1:0]  read_data_o,
	input  logic [`DISPATCH_WIDTH-1:0]               pop_i,
	// Wakeup
	input  preg_pkg::wb_mask_t                       wb_valid_i,
	input  preg_pkg::wb_preg_t                       wb_pdest_i
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	// Payload, no reset
	dq_pkg::dq_entry_t [DEPTH-1:0] mem_q, mem_n;

	logic [PTR_W-1:0] head_q, tail_q;
	logic [CNT_W-1:0] cnt_q;

	logic [`DECODE_WIDTH-1:0] push;
	logic [CNT_W-1:0]         push_cnt;
	logic [CNT_W-1:0]         pop_cnt;
	logic [PTR_W-1:0]         wr_idx;

	// ====================
	// Flow control
	// ====================

	// Room for a full write group, from registered count only
	assign write_ready_o = cnt_q <= CNT_W'(DEPTH - `DECODE_WIDTH);

	// A group offered while full is dropped whole
	assign push     = write_valid_i & {`DECODE_WIDTH{write_ready_o}};
	assign push_cnt = CNT_W'($countones(push));
	assign pop_cnt  = CNT_W'($countones(pop_i));

	// Head lanes, occupancy and data
	always_comb begin
		for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
			read_valid_o[i] = cnt_q > CNT_W'(i);
			read_data_o[i]  = mem_q[head_q + PTR_W'(i)];
		end
	end

	// ====================
	// Storage update
	// ====================

	always_comb begin
		mem_n  = mem_q;
		wr_idx = tail_q;
		// Wakeup, every entry against every writeback port
		for (int e = 0; e < DEPTH; e++) begin
			for (int w = 0; w < `WB_WIDTH; w++) begin
				if (wb_valid_i[w]) begin
					if (mem_q[e].src0 == wb_pdest_i[w]) begin
						mem_n[e].src0_ready = 1'b1;
					end
					if (mem_q[e].src1 == wb_pdest_i[w]) begin
						mem_n[e].src1_ready = 1'b1;
					end
				end
			end
		end
		// New entries overwrite the slot, ready bits come from lookup
		for (int i = 0; i < `DECODE_WIDTH; i++) begin
			wr_idx = tail_q + PTR_W'(i);
			if (push[i]) begin
				mem_n[wr_idx] = write_data_i[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		mem_q <= mem_n;
	end

	// Pointers and count
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head_q <= '0;
			tail_q <= '0;
			cnt_q  <= '0;
		end else if (flush_i) begin
			// Drop everything in flight
			head_q <= '0;
			tail_q <= '0;
			cnt_q  <= '0;
		end else begin
			head_q <= head_q + PTR_W'(pop_cnt);
			tail_q <= tail_q + PTR_W'(push_cnt);
			cnt_q  <= cnt_q + push_cnt - pop_cnt;
		end
	end

	// ====================
	// Checks
	// ====================

	// Pops only from occupied head lanes, lowest first
	a_pop_prefix: assert property (@(posedge clk) disable iff (!rst_n)
		((pop_i & ~read_valid_o) == '0) && ((pop_i & (pop_i + 1'b1)) == '0))
		else $error("dispatch_queue: pop mask is not a prefix of read_valid_o");

	// Producer fills lanes from lane 0 up
	a_write_contig: assert property (@(posedge clk) disable iff (!rst_n)
		(write_valid_i & (write_valid_i + 1'b1)) == '0)
		else $error("dispatch_queue: write lanes are not contiguous");

	a_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
		cnt_q <= CNT_W'(DEPTH))
		else $error("dispatch_queue: count above depth");

endmodule

`default_nettype wire

// File: rtl/dispatch_select.sv
// Dispatch select
// In-order readiness check on the queue head lanes, drives issue valids
// and the pop mask back to the queue

`default_nettype none

`include "dispatch_cfg.svh"

module dispatch_select (
	input  logic [`DISPATCH_WIDTH-1:0]               head_valid_i,
	input  dq_pkg::dq_entry_t [`DISPATCH_WIDTH-1:0]  head_data_i,
	input  logic [`DISPATCH_WIDTH-1:0]               iss_ready_i,
	output logic [`DISPATCH_WIDTH-1:0]               iss_valid_o,
	output logic [`DISPATCH_WIDTH-1:0]               pop_o
);

	// Present with both operands available
	logic [`DISPATCH_WIDTH-1:0] issuable;
	// Valid and accepted by the issue port
	logic [`DISPATCH_WIDTH-1:0] fire;
	// Chain term from the next older lane
	logic                       older_fire;

	// ====================
	// Readiness
	// ====================

	always_comb begin
		for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
			issuable[k] = head_valid_i[k] && head_data_i[k].src0_ready &&
				head_data_i[k].src1_ready;
		end
	end

	// ====================
	// In-order chain
	// ====================

	// A lane only offers if every older lane leaves this cycle
	always_comb begin
		older_fire = 1'b1;
		for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
			iss_valid_o[k] = issuable[k] && older_fire;
			fire[k]        = iss_valid_o[k] && iss_ready_i[k];
			older_fire     = fire[k];
		end
	end

	// First blocked lane stops everything younger
	assign pop_o = fire;

endmodule

`default_nettype wire

// File: rtl/dispatch_stage.sv
// Dispatch stage top
// Builds queue entries from renamed decode lanes with busy table lookup,
// and sends ready instructions to the issue ports in program order

`default_nettype none

`include "dispatch_cfg.svh"

module dispatch_stage (
	input  logic                                     clk,
	input  logic                                     rst_n,
	input  logic                                     flush_i,
	// Decode lanes
	input  logic [`DECODE_WIDTH-1:0]                 dec_valid_i,
	input  dq_pkg::op_e [`DECODE_WIDTH-1:0]          dec_op_i,
	input  dq_pkg::rob_t [`DECODE_WIDTH-1:0]         dec_rob_i,
	input  preg_pkg::preg_t [`DECODE_WIDTH-1:0]      dec_pdest_i,
	input  logic [`DECODE_WIDTH-1:0]                 dec_dest_en_i,
	input  preg_pkg::preg_t [`DECODE_WIDTH-1:0]      dec_src0_i,
	input  preg_pkg::preg_t [`DECODE_WIDTH-1:0]      dec_src1_i,
	input  logic [`DECODE_WIDTH-1:0]                 dec_src0_en_i,
	input  logic [`DECODE_WIDTH-1:0]                 dec_src1_en_i,
	output logic                                     dec_ready_o,
	// Writeback broadcast
	input  preg_pkg::wb_mask_t                       wb_valid_i,
	input  preg_pkg::wb_preg_t                       wb_pdest_i,
	// Issue lanes
	output logic [`DISPATCH_WIDTH-1:0]               iss_valid_o,
	output dq_pkg::op_e [`DISPATCH_WIDTH-1:0]        iss_op_o,
	output dq_pkg::rob_t [`DISPATCH_WIDTH-1:0]       iss_rob_o,
	output preg_pkg::preg_t [`DISPATCH_WIDTH-1:0]    iss_pdest_o,
	output preg_pkg::preg_t [`DISPATCH_WIDTH-1:0]    iss_src0_o,
	output preg_pkg::preg_t [`DISPATCH_WIDTH-1:0]    iss_src1_o,
	input  logic [`DISPATCH_WIDTH-1:0]               iss_ready_i
);

	logic [`DECODE_WIDTH-1:0]                src0_rdy, src1_rdy;
	logic [`DECODE_WIDTH-1:0]                alloc_valid;
	dq_pkg::dq_entry_t [`DECODE_WIDTH-1:0]   wr_entry;
	logic [`DISPATCH_WIDTH-1:0]              head_valid;
	dq_pkg::dq_entry_t [`DISPATCH_WIDTH-1:0] head_data;
	logic [`DISPATCH_WIDTH-1:0]              pop;

	// ====================
	// Entry build
	// ====================

	// Only accepted groups claim their destinations
	assign alloc_valid = dec_valid_i & dec_dest_en_i & {`DECODE_WIDTH{dec_ready_o}};

	always_comb begin
		for (int i = 0; i < `DECODE_WIDTH; i++) begin
			wr_entry[i].op         = dec_op_i[i];
			wr_entry[i].rob        = dec_rob_i[i];
			wr_entry[i].pdest      = dec_pdest_i[i];
			wr_entry[i].dest_en    = dec_dest_en_i[i];
			wr_entry[i].src0       = dec_src0_i[i];
			wr_entry[i].src1       = dec_src1_i[i];
			wr_entry[i].src0_ready = src0_rdy[i];
			wr_entry[i].src1_ready = src1_rdy[i];
		end
	end

	busy_table u_busy_table (
		.clk           (clk),
		.rst_n         (rst_n),
		.alloc_valid_i (alloc_valid),
		.alloc_pdest_i (dec_pdest_i),
		.wb_valid_i    (wb_valid_i),
		.wb_pdest_i    (wb_pdest_i),
		.look_src0_i   (dec_src0_i),
		.look_src1_i   (dec_src1_i),
		.look_en0_i    (dec_src0_en_i),
		.look_en1_i    (dec_src1_en_i),
		.src0_ready_o  (src0_rdy),
		.src1_ready_o  (src1_rdy)
	);

	dispatch_queue #(
		.DEPTH (`DQ_DEPTH)
	) u_dispatch_queue (
		.clk           (clk),
		.rst_n         (rst_n),
		.flush_i       (flush_i),
		.write_valid_i (dec_valid_i),
		.write_data_i  (wr_entry),
		.write_ready_o (dec_ready_o),
		.read_valid_o  (head_valid),
		.read_data_o   (head_data),
		.pop_i         (pop),
		.wb_valid_i    (wb_valid_i),
		.wb_pdest_i    (wb_pdest_i)
	);

	dispatch_select u_dispatch_select (
		.head_valid_i (head_valid),
		.head_data_i  (head_data),
		.iss_ready_i  (iss_ready_i),
		.iss_valid_o  (iss_valid_o),
		.pop_o        (pop)
	);

	// Issue fields straight from the head entries
	always_comb begin
		for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
			iss_op_o[k]    = head_data[k].op;
			iss_rob_o[k]   = head_data[k].rob;
			iss_pdest_o[k] = head_data[k].pdest;
			iss_src0_o[k]  = head_data[k].src0;
			iss_src1_o[k]  = head_data[k].src1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/dq_pkg.sv
// Dispatch queue package
// Opcode classes and the queue entry layout

`default_nettype none

package dq_pkg;

	// ROB slot index width
	localparam int ROB_W = 5;

	typedef logic [ROB_W-1:0] rob_t;

	// ====================
	// Opcode classes
	// ====================

	// Selects the issue port family
	typedef enum logic [2:0] {
		OP_ALU    = 3'd0,
		OP_MUL    = 3'd1,
		OP_LOAD   = 3'd2,
		OP_STORE  = 3'd3,
		OP_BRANCH = 3'd4
	} op_e;

	// ====================
	// Queue entry
	// ====================

	// Ready bits start from the busy table lookup
	// and get set later by writeback wakeup
	typedef struct packed {
		op_e           op;
		rob_t          rob;
		preg_pkg::preg_t pdest;
		logic          dest_en;
		preg_pkg::preg_t src0;
		preg_pkg::preg_t src1;
		logic          src0_ready;
		logic          src1_ready;
	} dq_entry_t;

endpackage

`default_nettype wire

// File: rtl/preg_pkg.sv
// Physical register package
// Register index and writeback port types

`default_nettype none

`include "dispatch_cfg.svh"

package preg_pkg;

	// Index width follows the register file size
	localparam int PREG_W = $clog2(`PHY_REG_NUM);

	// One physical register index
	typedef logic [PREG_W-1:0] preg_t;

	// ====================
	// Writeback broadcast
	// ====================

	// Valid bit per writeback port
	typedef logic [`WB_WIDTH-1:0] wb_mask_t;

	// Destination register per writeback port
	typedef preg_t [`WB_WIDTH-1:0] wb_preg_t;

endpackage

`default_nettype wire

// File: src.f
+incdir+rtl
rtl/preg_pkg.sv
rtl/dq_pkg.sv
rtl/busy_table.sv
rtl/dispatch_queue.sv
rtl/dispatch_select.sv
rtl/dispatch_stage.sv
verif/tb_dispatch_stage.sv

// File: verif/tb_dispatch_stage.sv
// Dispatch stage testbench
// Table of per-cycle steps with decode, writeback and issue ready inputs
// and hand-derived dec_ready_o and issue lane expectations

`default_nettype none

`include "dispatch_cfg.svh"

module tb_dispatch_stage;

	// ====================
	// DUT signals
	// ====================

	logic clk = 1'b0;
	logic rst_n;
	logic flush_i;
	logic [`DECODE_WIDTH-1:0] dec_valid_i, dec_dest_en_i, dec_src0_en_i, dec_src1_en_i;
	dq_pkg::op_e [`DECODE_WIDTH-1:0]       dec_op_i;
	dq_pkg::rob_t [`DECODE_WIDTH-1:0]      dec_rob_i;
	preg_pkg::preg_t [`DECODE_WIDTH-1:0]   dec_pdest_i, dec_src0_i, dec_src1_i;
	logic                                  dec_ready_o;
	preg_pkg::wb_mask_t                    wb_valid_i;
	preg_pkg::wb_preg_t                    wb_pdest_i;
	logic [`DISPATCH_WIDTH-1:0]            iss_valid_o, iss_ready_i;
	dq_pkg::op_e [`DISPATCH_WIDTH-1:0]     iss_op_o;
	dq_pkg::rob_t [`DISPATCH_WIDTH-1:0]    iss_rob_o;
	preg_pkg::preg_t [`DISPATCH_WIDTH-1:0] iss_pdest_o, iss_src0_o, iss_src1_o;

	dispatch_stage DUT (.*);

	always #20 clk = ~clk;

	// ====================
	// Step table
	// ====================

	// One decode lane of a step
	typedef struct packed {
		logic            v;
		dq_pkg::op_e     op;
		dq_pkg::rob_t    rob;
		logic            dest_en;
		preg_pkg::preg_t pdest;
		logic            s0_en;
		preg_pkg::preg_t src0;
		logic            s1_en;
		preg_pkg::preg_t src1;
	} lane_t;

	// Expected issue lane
	typedef struct packed {
		logic         v;
		dq_pkg::op_e  op;
		dq_pkg::rob_t rob;
	} iss_t;

	typedef struct packed {
		logic [2:0]                 tst;
		lane_t [`DECODE_WIDTH-1:0]  dec;
		preg_pkg::wb_mask_t         wbv;
		preg_pkg::wb_preg_t         wbp;
		logic [`DISPATCH_WIDTH-1:0] rdy;
		logic                       flush;
		// Expected in the same cycle
		logic                       dr;
		iss_t [`DISPATCH_WIDTH-1:0] want;
	} step_t;

	localparam lane_t       NOD    = '0;
	localparam iss_t        NOI    = '0;
	localparam dq_pkg::op_e ALU    = dq_pkg::OP_ALU;
	localparam dq_pkg::op_e MUL    = dq_pkg::OP_MUL;
	localparam dq_pkg::op_e LOAD   = dq_pkg::OP_LOAD;
	localparam dq_pkg::op_e STORE  = dq_pkg::OP_STORE;
	localparam dq_pkg::op_e BRANCH = dq_pkg::OP_BRANCH;

	step_t tbl[$];
	int    errors = 0;
	int    checks = 0;
	string names[7] = '{"", "dual write and issue", "busy source and wakeup",
		"in-order blocking", "queue full", "issue back-pressure", "flush"};

	// Negative register index means unused
	function automatic lane_t instr(dq_pkg::op_e op, int rob, int pdest, int src0, int src1);
		lane_t l;
		l         = '0;
		l.v       = 1'b1;
		l.op      = op;
		l.rob     = dq_pkg::rob_t'(rob);
		l.dest_en = pdest >= 0;
		l.pdest   = preg_pkg::preg_t'(pdest >= 0 ? pdest : 0);
		l.s0_en   = src0 >= 0;
		l.src0    = preg_pkg::preg_t'(src0 >= 0 ? src0 : 0);
		l.s1_en   = src1 >= 0;
		l.src1    = preg_pkg::preg_t'(src1 >= 0 ? src1 : 0);
		return l;
	endfunction

	// No destination and no sources
	function automatic lane_t bare(dq_pkg::op_e op, int rob);
		return instr(op, rob, -1, -1, -1);
	endfunction

	function automatic iss_t issue(dq_pkg::op_e op, int rob);
		iss_t e;
		e.v   = 1'b1;
		e.op  = op;
		e.rob = dq_pkg::rob_t'(rob);
		return e;
	endfunction

	// Decode lane in the table that carried this rob index
	function automatic lane_t sent_lane(dq_pkg::rob_t rob);
		lane_t l;
		l = '0;
		foreach (tbl[n]) begin
			for (int i = 0; i < `DECODE_WIDTH; i++) begin
				if (tbl[n].dec[i].v && tbl[n].dec[i].rob == rob) begin
					l = tbl[n].dec[i];
				end
			end
		end
		return l;
	endfunction

	// Writeback index below zero leaves that port idle
	task automatic step(int tst, lane_t d0, lane_t d1, int wb0, int wb1,
		logic [`DISPATCH_WIDTH-1:0] rdy, int fl, int dr, iss_t e0, iss_t e1);
		step_t s;
		s         = '0;
		s.tst     = 3'(tst);
		s.dec[0]  = d0;
		s.dec[1]  = d1;
		s.wbv     = {wb1 >= 0, wb0 >= 0};
		s.wbp[0]  = preg_pkg::preg_t'(wb0 >= 0 ? wb0 : 0);
		s.wbp[1]  = preg_pkg::preg_t'(wb1 >= 0 ? wb1 : 0);
		s.rdy     = rdy;
		s.flush   = fl != 0;
		s.dr      = dr != 0;
		s.want[0] = e0;
		s.want[1] = e1;
		tbl.push_back(s);
	endtask

	task automatic build_table();
		step(1, instr(ALU, 1, 1, -1, -1), instr(MUL, 2, 2, -1, -1), -1, -1, 2'b11, 0, 1, NOI, NOI);
		step(1, NOD, NOD, -1, -1, 2'b11, 0, 1, issue(ALU, 1), issue(MUL, 2));
		// p1 pending from step 0
		step(2, instr(LOAD, 3, 3, 1, -1), NOD, -1, -1, 2'b11, 0, 1, NOI, NOI);
		step(2, NOD, NOD, 1, -1, 2'b11, 0, 1, NOI, NOI);
		step(2, NOD, NOD, -1, -1, 2'b11, 0, 1, issue(LOAD, 3), NOI);
		// Bypass with both sources written back on entry
		step(2, instr(STORE, 4, -1, 2, 3), NOD, 2, 3, 2'b11, 0, 1, NOI, NOI);
		step(2, NOD, NOD, -1, -1, 2'b11, 0, 1, issue(STORE, 4), NOI);
		step(3, instr(MUL, 5, 5, -1, -1), NOD, -1, -1, 2'b11, 0, 1, NOI, NOI);
		step(3, instr(ALU, 6, 6, 5, -1), bare(BRANCH, 7), -1, -1, 2'b11, 0, 1,
			issue(MUL, 5), NOI);
		// Younger branch waits behind the ALU op
		step(3, NOD, NOD, -1, -1, 2'b11, 0, 1, NOI, NOI);
		step(3, NOD, NOD, 5, -1, 2'b11, 0, 1, NOI, NOI);
		step(3, NOD, NOD, -1, -1, 2'b11, 0, 1, issue(ALU, 6), issue(BRANCH, 7));
		// Fill with issue stalled
		step(4, bare(ALU, 8), bare(MUL, 9), -1, -1, 2'b00, 0, 1, NOI, NOI);
		step(4, bare(LOAD, 10), bare(STORE, 11), -1, -1, 2'b00, 0, 1, issue(ALU, 8), NOI);
		step(4, bare(BRANCH, 12), bare(ALU, 13), -1, -1, 2'b00, 0, 1, issue(ALU, 8), NOI);
		step(4, bare(MUL, 14), bare(LOAD, 15), -1, -1, 2'b00, 0, 1, issue(ALU, 8), NOI);
		// Count 8 so this group is dropped
		step(4, bare(BRANCH, 16), bare(BRANCH, 17), -1, -1, 2'b00, 0, 0, issue(ALU, 8), NOI);
		step(4, NOD, NOD, -1, -1, 2'b11, 0, 0, issue(ALU, 8), issue(MUL, 9));
		step(4, NOD, NOD, -1, -1, 2'b11, 0, 1, issue(LOAD, 10), issue(STORE, 11));
		step(4, NOD, NOD, -1, -1, 2'b11, 0, 1, issue(BRANCH, 12), issue(ALU, 13));
		step(4, NOD, NOD, -1, -1, 2'b11, 0, 1, issue(MUL, 14), issue(LOAD, 15));
		step(4, NOD, NOD, -1, -1, 2'b11, 0, 1, NOI, NOI);
		step(5, bare(ALU, 18), bare(MUL, 19), -1, -1, 2'b11, 0, 1, NOI, NOI);
		step(5, NOD, NOD, -1, -1, 2'b00, 0, 1, issue(ALU, 18), NOI);
		// Lane 1 ready alone moves nothing
		step(5, NOD, NOD, -1, -1, 2'b10, 0, 1, issue(ALU, 18), NOI);
		step(5, NOD, NOD, -1, -1, 2'b01, 0, 1, issue(ALU, 18), issue(MUL, 19));
		step(5, NOD, NOD, -1, -1, 2'b11, 0, 1, issue(MUL, 19), NOI);
		// p6 still pending since the blocking test
		step(6, instr(LOAD, 20, 7, -1, -1), instr(STORE, 21, -1, 6, -1), -1, -1, 2'b00, 0, 1,
			NOI, NOI);
		step(6, NOD, NOD, -1, -1, 2'b00, 1, 1, issue(LOAD, 20), NOI);
		step(6, NOD, NOD, -1, -1, 2'b11, 0, 1, NOI, NOI);
		// p7 survives the flush
		step(6, instr(MUL, 22, -1, 7, -1), NOD, -1, -1, 2'b11, 0, 1, NOI, NOI);
		step(6, NOD, NOD, -1, -1, 2'b11, 0, 1, NOI, NOI);
		step(6, NOD, NOD, -1, 7, 2'b11, 0, 1, NOI, NOI);
		step(6, NOD, NOD, -1, -1, 2'b11, 0, 1, issue(MUL, 22), NOI);
		step(6, NOD, NOD, -1, -1, 2'b11, 0, 1, NOI, NOI);
	endtask

	// ====================
	// Drive and compare
	// ====================

	task automatic drive(step_t s);
		for (int i = 0; i < `DECODE_WIDTH; i++) begin
			dec_valid_i[i]   = s.dec[i].v;
			dec_op_i[i]      = s.dec[i].op;
			dec_rob_i[i]     = s.dec[i].rob;
			dec_pdest_i[i]   = s.dec[i].pdest;
			dec_dest_en_i[i] = s.dec[i].dest_en;
			dec_src0_i[i]    = s.dec[i].src0;
			dec_src0_en_i[i] = s.dec[i].s0_en;
			dec_src1_i[i]    = s.dec[i].src1;
			dec_src1_en_i[i] = s.dec[i].s1_en;
		end
		wb_valid_i  = s.wbv;
		wb_pdest_i  = s.wbp;
		iss_ready_i = s.rdy;
		flush_i     = s.flush;
	endtask

	task automatic check(logic [31:0] got, logic [31:0] want, string what);
		checks++;
		if (got !== want) begin
			errors++;
			$display("Fail at %0t: %s is %0h, expected %0h", $time, what, got, want);
		end
	endtask

	// Issue fields only matter on a valid lane
	// Register fields come back as the decode lane sent them
	task automatic check_outputs(int n, step_t s);
		lane_t sent;
		check(32'(dec_ready_o), 32'(s.dr), $sformatf("step %0d dec_ready_o", n));
		for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
			check(32'(iss_valid_o[k]), 32'(s.want[k].v),
				$sformatf("step %0d iss_valid_o[%0d]", n, k));
			if (s.want[k].v) begin
				sent = sent_lane(s.want[k].rob);
				check(32'(iss_op_o[k]), 32'(s.want[k].op),
					$sformatf("step %0d iss_op_o[%0d]", n, k));
				check(32'(iss_rob_o[k]), 32'(s.want[k].rob),
					$sformatf("step %0d iss_rob_o[%0d]", n, k));
				check(32'(iss_pdest_o[k]), 32'(sent.pdest),
					$sformatf("step %0d iss_pdest_o[%0d]", n, k));
				check(32'(iss_src0_o[k]), 32'(sent.src0),
					$sformatf("step %0d iss_src0_o[%0d]", n, k));
				check(32'(iss_src1_o[k]), 32'(sent.src1),
					$sformatf("step %0d iss_src1_o[%0d]", n, k));
			end
		end
	endtask

	// ====================
	// Sequence
	// ====================

	initial begin
		int start_err;
		int tests;
		build_table();
		rst_n = 1'b0;
		drive('0);
		repeat (3) @(posedge clk);
		#5;
		rst_n     = 1'b1;
		start_err = 0;
		tests     = 0;
		for (int n = 0; n < tbl.size(); n++) begin
			@(posedge clk);
			#5;
			drive(tbl[n]);
			// Settled well before the next edge
			#15;
			check_outputs(n, tbl[n]);
			if (n == tbl.size() - 1 || tbl[n + 1].tst != tbl[n].tst) begin
				tests++;
				$display("Test %0d %s: %s", tbl[n].tst, names[tbl[n].tst],
					(errors == start_err) ? "ok" : "mismatch");
				start_err = errors;
			end
		end
		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// Reset plus one cycle per step plus margin
	initial begin
		#1;
		#((tbl.size() + 12) * 40);
		$display("Timeout: the run did not finish its steps, stopped at %0t", $time);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire
